// File: include/noc_router_macros.svh
/* Shared sizing for the mesh router, included by the package and the RTL modules
   that size their ports or storage from these values */
`ifndef NOC_ROUTER_MACROS_SVH
`define NOC_ROUTER_MACROS_SVH

////////////////////////////////////////////////////////////
// Link sizing
////////////////////////////////////////////////////////////

// Flit payload width, preamble bits excluded
`define NOC_DATA_WIDTH 32

// Width of a single x or y coordinate
`define NOC_COORD_WIDTH 3

// Entries per input queue
`define NOC_FIFO_DEPTH 4

// North, south, west, east and local
`define NOC_PORTS 5

`endif

// File: verilog/noc_router_pkg.sv
/* Types shared by the router modules and the XY next-hop routing function.
   Import it wherever flits, directions or coordinates are handled */
`default_nettype none

`include "noc_router_macros.svh"

package noc_router_pkg;

  ////////////////////////////////////////////////////////////
  // Ports and directions
  ////////////////////////////////////////////////////////////

  // Port index, also the bit position in a direction mask
  typedef enum logic [2:0] {
    port_north = 3'd0,
    port_south = 3'd1,
    port_west  = 3'd2,
    port_east  = 3'd3,
    port_local = 3'd4
  } port_e;

  // One-hot direction, one bit per port
  typedef logic [`NOC_PORTS-1:0] dir_t;

  // Tile coordinates, x in the upper bits
  typedef struct packed {
    logic [`NOC_COORD_WIDTH-1:0] x;
    logic [`NOC_COORD_WIDTH-1:0] y;
  } xy_t;

  ////////////////////////////////////////////////////////////
  // Flit layout
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic head;
    logic tail;
  } preamble_t;

  // Whatever the data word leaves after the routing information
  localparam int unsigned reserved_width =
    `NOC_DATA_WIDTH - 2 * $bits(xy_t) - 8 - $bits(dir_t);

  typedef struct packed {
    preamble_t                 preamble;
    xy_t                       source;
    xy_t                       destination;
    logic [7:0]                message;
    logic [reserved_width-1:0] reserved;
    // Output to take at the router that receives this flit
    dir_t                      routing;
  } header_t;

  typedef union packed {
    header_t                     header;
    logic [`NOC_DATA_WIDTH+1:0]  raw;
  } flit_t;

  // XY dimension order, x resolved first
  function automatic dir_t next_hop(input xy_t position, input xy_t destination);
    dir_t result;
    result = '0;
    if (destination.x > position.x) begin
      result[port_east] = 1'b1;
    end else if (destination.x < position.x) begin
      result[port_west] = 1'b1;
    end else if (destination.y > position.y) begin
      result[port_south] = 1'b1;
    end else if (destination.y < position.y) begin
      result[port_north] = 1'b1;
    end else begin
      result[port_local] = 1'b1;
    end
    return result;
  endfunction

endpackage

`default_nettype wire

// File: verilog/input_queue.sv
/* Input port of the router: bypassable flit FIFO plus the output request held
   for the worm in flight. One instance per link */
`timescale 1ns/100ps
`default_nettype none

`include "noc_router_macros.svh"

module input_queue (
  input  logic                  clk,
  input  logic                  rst,
  input  noc_router_pkg::flit_t flit_i,
  input  logic                  void_i,
  input  logic                  read_i,
  output noc_router_pkg::flit_t head_o,
  output logic                  empty_o,
  output logic                  full_o,
  output noc_router_pkg::dir_t  request_o
);
  import noc_router_pkg::*;

  localparam int unsigned depth     = `NOC_FIFO_DEPTH;
  localparam int unsigned ptr_width = $clog2(depth);
  localparam int unsigned cnt_width = $clog2(depth + 1);

  flit_t                mem [0:depth-1];
  logic [ptr_width-1:0] wr_ptr_q;
  logic [ptr_width-1:0] rd_ptr_q;
  logic [cnt_width-1:0] count_q;
  logic                 fifo_empty;
  logic                 push;
  logic                 pop;
  logic                 head_valid;
  dir_t                 saved_req_q;

  assign fifo_empty = (count_q == '0);

  // Empty FIFO hands the incoming flit straight to the crossbar
  assign head_o  = fifo_empty ? flit_i : mem[rd_ptr_q];
  assign empty_o = fifo_empty & void_i;

  // A bypassed flit read in its arrival cycle is never stored
  assign push = ~void_i & ~(fifo_empty & read_i);
  assign pop  = read_i & ~fifo_empty;

  // Stop one entry early, the sender may still launch one flit after stop
  assign full_o = (count_q >= cnt_width'(depth - 1));

  ////////////////////////////////////////////////////////////
  // FIFO storage and pointers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= flit_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_width'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_width'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Worm request
  ////////////////////////////////////////////////////////////

  assign head_valid = ~empty_o & head_o.header.preamble.head;

  // Routing field sampled when the head leaves, dropped with the tail
  always_ff @(posedge clk) begin
    if (rst) begin
      saved_req_q <= '0;
    end else if (read_i & head_o.header.preamble.tail) begin
      saved_req_q <= '0;
    end else if (read_i & head_o.header.preamble.head) begin
      saved_req_q <= head_o.header.routing;
    end
  end

  // Waiting head asks directly, body flits inherit the saved request
  assign request_o = head_valid ? head_o.header.routing : saved_req_q;

endmodule

`default_nettype wire

// File: verilog/router_arbiter.sv
/* Round-robin arbiter of one output port. The grant locks onto a worm and is
   released by its tail flit, after which priority moves past the winner */
`timescale 1ns/100ps
`default_nettype none

`include "noc_router_macros.svh"

module router_arbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NOC_PORTS-2:0] request_i,
  input  logic                  release_i,
  output logic [`NOC_PORTS-2:0] grant_o,
  output logic                  grant_valid_o
);

  // The port itself is never a source, so one input less
  localparam int unsigned num_inputs = `NOC_PORTS - 1;
  localparam int unsigned idx_width  = $clog2(num_inputs);

  logic [idx_width-1:0] pointer_q;
  logic [idx_width-1:0] held_q;
  logic [idx_width-1:0] pick_idx;
  logic [idx_width-1:0] cur_idx;
  logic                 locked_q;

  // First requester at or after the pointer, walking upward
  always_comb begin : pick_logic
    int idx;
    pick_idx = pointer_q;
    for (int i = num_inputs - 1; i >= 0; i--) begin
      idx = (int'(pointer_q) + i) % num_inputs;
      if (request_i[idx]) begin
        pick_idx = idx[idx_width-1:0];
      end
    end
  end

  // Held winner while locked, fresh pick otherwise
  assign cur_idx       = locked_q ? held_q : pick_idx;
  assign grant_valid_o = locked_q | (|request_i);

  always_comb begin
    grant_o = '0;
    if (grant_valid_o) begin
      grant_o[cur_idx] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Lock and priority rotation
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      locked_q  <= 1'b0;
      pointer_q <= '0;
    end else if (release_i) begin
      // Tail gone, the next worm may compete
      locked_q  <= 1'b0;
      pointer_q <= (int'(cur_idx) == num_inputs - 1) ? '0 : cur_idx + 1'b1;
    end else if (~locked_q & (|request_i)) begin
      locked_q <= 1'b1;
    end
  end

  // Pick result frozen while locked
  always_ff @(posedge clk) begin
    if (~locked_q) begin
      held_q <= pick_idx;
    end
  end

endmodule

`default_nettype wire

// File: verilog/lookahead_route.sv
/* Look-ahead route computation: given the output a head flit takes here, finds
   the output it must take at the neighbouring router. Purely combinational */
`timescale 1ns/100ps
`default_nettype none

module lookahead_route (
  input  noc_router_pkg::xy_t   position_i,
  input  noc_router_pkg::xy_t   destination_i,
  input  noc_router_pkg::port_e out_port_i,
  output noc_router_pkg::dir_t  next_o
);
  import noc_router_pkg::*;

  xy_t neighbour;

  // Position of the tile behind the chosen output
  always_comb begin
    neighbour = position_i;
    case (out_port_i)
      port_north: neighbour.y = position_i.y - 1'b1;
      port_south: neighbour.y = position_i.y + 1'b1;
      port_west:  neighbour.x = position_i.x - 1'b1;
      port_east:  neighbour.x = position_i.x + 1'b1;
      default:    neighbour = position_i;
    endcase
  end

  always_comb begin
    if (out_port_i == port_local) begin
      // Ejected here, the field is unused downstream
      next_o             = '0;
      next_o[port_local] = 1'b1;
    end else begin
      next_o = next_hop(neighbour, destination_i);
    end
  end

endmodule

`default_nettype wire

// File: verilog/output_port.sv
/* One output of the router: arbitration, crossbar select, look-ahead rewrite of
   the head flit and the registered link stage with stop/void handling */
`timescale 1ns/100ps
`default_nettype none

`include "noc_router_macros.svh"

module output_port #(
  parameter noc_router_pkg::port_e OutPort = noc_router_pkg::port_local
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  noc_router_pkg::xy_t                    position_i,
  input  noc_router_pkg::flit_t [`NOC_PORTS-1:0] heads_i,
  input  logic                  [`NOC_PORTS-1:0] empty_i,
  input  noc_router_pkg::dir_t  [`NOC_PORTS-1:0] requests_i,
  input  logic                                   stop_i,
  output logic                  [`NOC_PORTS-1:0] read_o,
  output noc_router_pkg::flit_t                  flit_o,
  output logic                                   void_o
);
  import noc_router_pkg::*;

  typedef enum logic [1:0] {
    st_reserve = 2'd0,
    st_head    = 2'd1,
    st_payload = 2'd2
  } state_e;

  state_e                  state_q;
  state_e                  state_d;
  logic [`NOC_PORTS-2:0]   arb_req;
  logic [`NOC_PORTS-2:0]   arb_grant;
  logic                    arb_valid;
  logic [`NOC_PORTS-1:0]   sel;
  flit_t                   sel_flit;
  logic                    sel_avail;
  flit_t                   out_flit;
  dir_t                    next_route;
  logic                    fwd;
  logic                    fwd_tail;
  flit_t                   flit_q;
  logic                    void_q;

  ////////////////////////////////////////////////////////////
  // Arbitration among the other four inputs
  ////////////////////////////////////////////////////////////

  // Arbiter slot k skips this port's own input
  for (genvar j = 0; j < `NOC_PORTS; j++) begin : gen_map
    if (j < int'(OutPort)) begin : gen_below
      assign arb_req[j] = requests_i[j][OutPort];
      assign sel[j]     = arb_grant[j];
    end else if (j > int'(OutPort)) begin : gen_above
      assign arb_req[j-1] = requests_i[j][OutPort];
      assign sel[j]       = arb_grant[j-1];
    end else begin : gen_self
      assign sel[j] = 1'b0;
    end
  end

  router_arbiter u_arbiter (
    .clk           (clk),
    .rst           (rst),
    .request_i     (arb_req),
    .release_i     (fwd_tail),
    .grant_o       (arb_grant),
    .grant_valid_o (arb_valid)
  );

  ////////////////////////////////////////////////////////////
  // Crossbar and head rewrite
  ////////////////////////////////////////////////////////////

  always_comb begin
    sel_flit  = '0;
    sel_avail = 1'b0;
    for (int j = 0; j < `NOC_PORTS; j++) begin
      if (sel[j]) begin
        sel_flit  = heads_i[j];
        sel_avail = ~empty_i[j];
      end
    end
  end

  lookahead_route u_lookahead (
    .position_i    (position_i),
    .destination_i (sel_flit.header.destination),
    .out_port_i    (OutPort),
    .next_o        (next_route)
  );

  // Only the head carries routing, body words pass untouched
  always_comb begin
    out_flit = sel_flit;
    if (state_q != st_payload) begin
      out_flit.header.routing = next_route;
    end
  end

  // A stop seen this cycle blocks the next transfer
  assign fwd      = arb_valid & sel_avail & ~stop_i;
  assign fwd_tail = fwd & sel_flit.header.preamble.tail;
  assign read_o   = sel & {`NOC_PORTS{fwd}};

  ////////////////////////////////////////////////////////////
  // Worm FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_reserve: begin
        // Free port with a clear link sends the head at once
        if (arb_valid) begin
          if (fwd) begin
            state_d = sel_flit.header.preamble.tail ? st_reserve : st_payload;
          end else begin
            state_d = st_head;
          end
        end
      end
      st_head: begin
        if (fwd) begin
          state_d = sel_flit.header.preamble.tail ? st_reserve : st_payload;
        end
      end
      st_payload: begin
        if (fwd_tail) begin
          state_d = st_reserve;
        end
      end
      default: state_d = st_reserve;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_reserve;
      void_q  <= 1'b1;
    end else begin
      state_q <= state_d;
      void_q  <= ~fwd;
    end
  end

  // Output register holds its value under stop
  always_ff @(posedge clk) begin
    if (fwd) begin
      flit_q <= out_flit;
    end
  end

  assign flit_o = flit_q;
  assign void_o = void_q;

endmodule

`default_nettype wire

// File: verilog/noc_router.sv
/* Top level of the five-port mesh router. Maps the named links onto port arrays
   and connects the input queues to the output ports */
`timescale 1ns/100ps
`default_nettype none

`include "noc_router_macros.svh"

module noc_router (
  input  logic                  clk,
  input  logic                  rst,
  input  noc_router_pkg::xy_t   position_i,
  // Incoming links
  input  noc_router_pkg::flit_t data_n_i,
  input  noc_router_pkg::flit_t data_s_i,
  input  noc_router_pkg::flit_t data_w_i,
  input  noc_router_pkg::flit_t data_e_i,
  input  noc_router_pkg::flit_t data_p_i,
  input  logic [`NOC_PORTS-1:0] data_void_i,
  output logic [`NOC_PORTS-1:0] stop_o,
  // Outgoing links
  output noc_router_pkg::flit_t data_n_o,
  output noc_router_pkg::flit_t data_s_o,
  output noc_router_pkg::flit_t data_w_o,
  output noc_router_pkg::flit_t data_e_o,
  output noc_router_pkg::flit_t data_p_o,
  output logic [`NOC_PORTS-1:0] data_void_o,
  input  logic [`NOC_PORTS-1:0] stop_i
);
  import noc_router_pkg::*;

  flit_t [`NOC_PORTS-1:0]                 data_in;
  flit_t [`NOC_PORTS-1:0]                 data_out;
  flit_t [`NOC_PORTS-1:0]                 heads;
  logic  [`NOC_PORTS-1:0]                 empty;
  logic  [`NOC_PORTS-1:0]                 full;
  dir_t  [`NOC_PORTS-1:0]                 requests;
  // Indexed by output first, then input
  logic  [`NOC_PORTS-1:0][`NOC_PORTS-1:0] read_strobe;
  logic  [`NOC_PORTS-1:0]                 read_or;

  assign data_in[port_north] = data_n_i;
  assign data_in[port_south] = data_s_i;
  assign data_in[port_west]  = data_w_i;
  assign data_in[port_east]  = data_e_i;
  assign data_in[port_local] = data_p_i;

  assign data_n_o = data_out[port_north];
  assign data_s_o = data_out[port_south];
  assign data_w_o = data_out[port_west];
  assign data_e_o = data_out[port_east];
  assign data_p_o = data_out[port_local];

  assign stop_o = full;

  // At most one output reads a given input in any cycle
  always_comb begin
    read_or = '0;
    for (int o = 0; o < `NOC_PORTS; o++) begin
      read_or = read_or | read_strobe[o];
    end
  end

  ////////////////////////////////////////////////////////////
  // Input queues and output ports
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < `NOC_PORTS; g++) begin : gen_port
    input_queue u_in (
      .clk       (clk),
      .rst       (rst),
      .flit_i    (data_in[g]),
      .void_i    (data_void_i[g]),
      .read_i    (read_or[g]),
      .head_o    (heads[g]),
      .empty_o   (empty[g]),
      .full_o    (full[g]),
      .request_o (requests[g])
    );

    output_port #(
      .OutPort (port_e'(g))
    ) u_out (
      .clk        (clk),
      .rst        (rst),
      .position_i (position_i),
      .heads_i    (heads),
      .empty_i    (empty),
      .requests_i (requests),
      .stop_i     (stop_i[g]),
      .read_o     (read_strobe[g]),
      .flit_o     (data_out[g]),
      .void_o     (data_void_o[g])
    );
  end

endmodule

`default_nettype wire

// File: test/noc_router_asserts.sv
/* Concurrent checks on link flow control and crossbar reads of the router,
   attached to every noc_router instance through bind */
`timescale 1ns/100ps
`default_nettype none

`include "noc_router_macros.svh"

module noc_router_asserts (
  input logic                                   clk,
  input logic                                   rst,
  input logic [`NOC_PORTS-1:0]                  stop_i,
  input logic [`NOC_PORTS-1:0]                  stop_o,
  input logic [`NOC_PORTS-1:0]                  data_void_i,
  input logic [`NOC_PORTS-1:0]                  data_void_o,
  input logic [`NOC_PORTS-1:0][`NOC_PORTS-1:0]  read_strobe_i
);

  // Links come out of reset idle
  a_void_after_reset: assert property (@(posedge clk) $fell(rst) |-> &data_void_o)
    else $error("data_void_o not all high after reset");

  for (genvar g = 0; g < `NOC_PORTS; g++) begin : gen_link
    logic [`NOC_PORTS-1:0] column;

    // Outputs reading input g
    for (genvar k = 0; k < `NOC_PORTS; k++) begin : gen_column
      assign column[k] = read_strobe_i[k][g];
    end

    a_void_after_stop: assert property (
      @(posedge clk) disable iff (rst) stop_i[g] |=> data_void_o[g])
      else $error("output %0d sent a flit after stop", g);

    a_sender_obeys_stop: assert property (
      @(posedge clk) disable iff (rst) stop_o[g] |=> data_void_i[g])
      else $error("input %0d received a flit after stop", g);

    a_single_reader: assert property (@(posedge clk) disable iff (rst) $onehot0(column))
      else $error("input %0d read by several outputs", g);
  end

endmodule

bind noc_router noc_router_asserts u_asserts (
  .clk           (clk),
  .rst           (rst),
  .stop_i        (stop_i),
  .stop_o        (stop_o),
  .data_void_i   (data_void_i),
  .data_void_o   (data_void_o),
  .read_strobe_i (read_strobe)
);

`default_nettype wire

// File: test/tb_noc_router.sv
/* Testbench of the mesh router. Packets and expected routes come from the golden
   file, delivered flits are checked per output under random stop levels */
`timescale 1ns/100ps
`default_nettype none

`include "noc_router_macros.svh"

module tb_noc_router;
  import noc_router_pkg::*;

  localparam int num_packets = 14;
  localparam int num_cols    = 6;
  localparam int col_in      = 0;
  localparam int col_dest    = 1;
  localparam int col_len     = 2;
  localparam int col_first   = 3;
  localparam int col_out     = 4;
  localparam int col_route   = 5;
  // Last packet of the random stop phase, the rest form the flood phase
  localparam int mixed_last  = 10;

  logic                  clk;
  logic                  rst;
  xy_t                   position;
  flit_t                 in_flit [`NOC_PORTS];
  flit_t                 out_flit [`NOC_PORTS];
  logic [`NOC_PORTS-1:0] void_in;
  logic [`NOC_PORTS-1:0] void_out;
  logic [`NOC_PORTS-1:0] stop_in;
  logic [`NOC_PORTS-1:0] stop_out;
  logic [31:0]           golden_mem [0:num_packets*num_cols-1];

  integer                seed;
  int                    mismatches;
  int                    failures;
  int                    cycle;
  int                    cycle_limit;
  // 0 idle, 1 random, 2 all outputs stopped
  int                    stop_mode;
  logic [`NOC_PORTS-1:0] stop_seen;
  logic [`NOC_PORTS-1:0] prev_stop;
  logic                  saw_full;
  int                    cur_pkt [`NOC_PORTS];
  int                    cur_idx [`NOC_PORTS];
  int                    last_pkt [`NOC_PORTS];
  bit                    delivered [num_packets];
  int                    done_count;

  noc_router dut_i (
    .clk         (clk),
    .rst         (rst),
    .position_i  (position),
    .data_n_i    (in_flit[0]),
    .data_s_i    (in_flit[1]),
    .data_w_i    (in_flit[2]),
    .data_e_i    (in_flit[3]),
    .data_p_i    (in_flit[4]),
    .data_void_i (void_in),
    .stop_o      (stop_out),
    .data_n_o    (out_flit[0]),
    .data_s_o    (out_flit[1]),
    .data_w_o    (out_flit[2]),
    .data_e_o    (out_flit[3]),
    .data_p_o    (out_flit[4]),
    .data_void_o (void_out),
    .stop_i      (stop_in)
  );

  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Golden data and flit building
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] golden_field(input int pkt, input int col);
    return golden_mem[pkt*num_cols + col];
  endfunction

  // Head carries the port index as source and the packet number as message
  function automatic flit_t make_flit(input int pkt, input int k, input bit routed);
    flit_t f;
    int    len;
    len = int'(golden_field(pkt, col_len));
    f = '0;
    if (k == 0) begin
      f.header.preamble.head = 1'b1;
      f.header.source        = xy_t'(golden_field(pkt, col_in));
      f.header.destination   = xy_t'(golden_field(pkt, col_dest));
      f.header.message       = 8'(pkt);
      if (routed) begin
        f.header.routing = dir_t'(golden_field(pkt, col_route));
      end else begin
        f.header.routing = dir_t'(32'd1 << golden_field(pkt, col_out));
      end
    end else begin
      f.raw[`NOC_DATA_WIDTH-1:0] = golden_field(pkt, col_first) + 32'(k - 1);
    end
    f.header.preamble.tail = (k == len - 1);
    return f;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Sends the packets of one input in golden order, holding void after a stop
  task automatic inject_port(input int p, input int first, input int last);
    int len;
    for (int i = first; i <= last; i++) begin
      if (int'(golden_field(i, col_in)) == p) begin
        len = int'(golden_field(i, col_len));
        for (int k = 0; k < len; k++) begin
          @(posedge clk);
          #1;
          while (stop_seen[p]) begin
            void_in[p] = 1'b1;
            @(posedge clk);
            #1;
          end
          in_flit[p] = make_flit(i, k, 1'b0);
          void_in[p] = 1'b0;
        end
      end
    end
    @(posedge clk);
    #1;
    void_in[p] = 1'b1;
  endtask

  task automatic wait_done(input int target);
    while (done_count < target) begin
      @(posedge clk);
    end
  endtask

  always @(posedge clk) begin
    #1;
    case (stop_mode)
      1: begin
        for (int b = 0; b < `NOC_PORTS; b++) begin
          stop_in[b] = (($random(seed) & 3) == 0);
        end
      end
      2:       stop_in = '1;
      default: stop_in = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////

  task automatic finish_packet(input int o);
    delivered[cur_pkt[o]] = 1'b1;
    done_count++;
    cur_pkt[o] = -1;
  endtask

  task automatic take_flit(input int o, input flit_t f);
    int pkt;
    int src;
    if (prev_stop[o]) begin
      failures++;
      $display("output %0d sent a flit in the cycle after its stop", o);
    end
    if (cur_pkt[o] < 0) begin
      pkt = int'(f.header.message);
      if (!f.header.preamble.head || pkt >= num_packets) begin
        failures++;
        $display("output %0d delivered a flit that starts no known packet", o);
      end else begin
        src = int'(golden_field(pkt, col_in));
        check_value($sformatf("out_port[%0d]", pkt), 64'(o), 64'(golden_field(pkt, col_out)));
        check_value($sformatf("routing[%0d]", pkt), 64'(f.header.routing),
                    64'(golden_field(pkt, col_route)));
        check_value($sformatf("head[%0d]", pkt), 64'(f.raw), 64'(make_flit(pkt, 0, 1'b1).raw));
        if (delivered[pkt]) begin
          failures++;
          $display("packet %0d was delivered twice", pkt);
        end
        if (pkt <= last_pkt[src]) begin
          failures++;
          $display("packet %0d from input %0d arrived out of order", pkt, src);
        end
        last_pkt[src] = pkt;
        cur_pkt[o]    = pkt;
        cur_idx[o]    = 1;
        if (golden_field(pkt, col_len) == 32'd1) begin
          finish_packet(o);
        end
      end
    end else begin
      // A foreign head here means two worms interleaved
      check_value($sformatf("flit[%0d][%0d]", cur_pkt[o], cur_idx[o]), 64'(f.raw),
                  64'(make_flit(cur_pkt[o], cur_idx[o], 1'b1).raw));
      cur_idx[o]++;
      if (cur_idx[o] == int'(golden_field(cur_pkt[o], col_len))) begin
        finish_packet(o);
      end
    end
  endtask

  // Mid-cycle sampling, every link signal is settled here
  always @(negedge clk) begin
    stop_seen = stop_out;
    if (!rst) begin
      if (stop_out[port_local]) begin
        saw_full = 1'b1;
      end
      for (int o = 0; o < `NOC_PORTS; o++) begin
        if (!void_out[o]) begin
          take_flit(o, out_flit[o]);
        end
      end
      prev_stop = stop_in;
    end
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle_limit > 0 && cycle > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int total_flits;
    clk         = 1'b0;
    rst         = 1'b1;
    position    = '{x: 3'd3, y: 3'd3};
    void_in     = '1;
    stop_in     = '0;
    seed        = 25;
    mismatches  = 0;
    failures    = 0;
    cycle       = 0;
    cycle_limit = 0;
    stop_mode   = 0;
    stop_seen   = '0;
    prev_stop   = '0;
    saw_full    = 1'b0;
    done_count  = 0;
    for (int p = 0; p < `NOC_PORTS; p++) begin
      in_flit[p]  = '0;
      cur_pkt[p]  = -1;
      cur_idx[p]  = 0;
      last_pkt[p] = -1;
    end
    for (int i = 0; i < num_packets; i++) begin
      delivered[i] = 1'b0;
    end

    $readmemh("test/noc_router_golden.hex", golden_mem);
    total_flits = 0;
    for (int i = 0; i < num_packets; i++) begin
      total_flits += int'(golden_field(i, col_len));
    end
    cycle_limit = total_flits * 20 + 200;

    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_value("data_void_o", 64'(void_out), 64'(5'h1f));
    check_value("stop_o", 64'(stop_out), 64'(0));

    // Single flit from local, registered on east one cycle later
    @(posedge clk);
    #1;
    in_flit[port_local] = make_flit(0, 0, 1'b0);
    void_in[port_local] = 1'b0;
    @(posedge clk);
    #1;
    void_in[port_local] = 1'b1;
    check_value("data_void_o[east]", 64'(void_out[port_east]), 64'(0));
    check_value("data_e_o", 64'(out_flit[port_east].raw), 64'(make_flit(0, 0, 1'b1).raw));
    wait_done(1);

    // All inputs at once, several worms share one output
    stop_mode = 1;
    fork
      inject_port(0, 1, mixed_last);
      inject_port(1, 1, mixed_last);
      inject_port(2, 1, mixed_last);
      inject_port(3, 1, mixed_last);
      inject_port(4, 1, mixed_last);
    join
    wait_done(mixed_last + 1);

    // Flood with every output stopped until the local queue fills
    saw_full  = 1'b0;
    stop_mode = 2;
    fork
      begin
        repeat (12) @(posedge clk);
        stop_mode = 1;
      end
      inject_port(0, mixed_last + 1, num_packets - 1);
      inject_port(1, mixed_last + 1, num_packets - 1);
      inject_port(2, mixed_last + 1, num_packets - 1);
      inject_port(3, mixed_last + 1, num_packets - 1);
      inject_port(4, mixed_last + 1, num_packets - 1);
    join
    wait_done(num_packets);
    stop_mode = 0;
    repeat (5) @(posedge clk);

    if (!saw_full) begin
      failures++;
      $display("stop_o of the local input never rose during the flood");
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: noc_router.f
+incdir+include
verilog/noc_router_pkg.sv
verilog/input_queue.sv
verilog/router_arbiter.sv
verilog/lookahead_route.sv
verilog/output_port.sv
verilog/noc_router.sv
test/noc_router_asserts.sv
test/tb_noc_router.sv

// File: Makefile
# Verilator build and run of the mesh router testbench
VERILATOR ?= verilator
TOP       ?= tb_noc_router
FILELIST  ?= noc_router.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard verilog/*.sv test/*.sv include/*.svh) test/noc_router_golden.hex

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, a crash or assertion stop also fails
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/noc_router_golden.hex
// Router at x=3 y=3. Columns: input port, destination (x*8+y), length in flits,
// first payload word, expected output port, expected routing field (N=01 S=02 W=04 E=08 L=10)
4 2B 1 A0000000 3 08
2 31 3 B1000000 3 08
0 23 4 C2000000 3 10
4 25 2 D3000000 3 02
1 0B 3 E4000000 2 04
3 18 2 F5000000 0 01
4 1E 5 16000000 1 02
2 1B 3 27000000 4 10
0 1C 2 38000000 1 10
3 15 4 49000000 2 02
1 1A 1 5A000000 0 10
4 03 6 6B000000 2 04
3 1B 2 7C000000 4 10
2 3F 3 8D000000 3 08
